/* hw/decodePkg.sv */
package decodePkg;

	localparam int xLen = 32; // Instruction and address width

	// Major opcodes of the RV32IM integer classes
	typedef enum logic [6:0]
	{
		opcLoad   = 7'b0000011,
		opcOpImm  = 7'b0010011,
		opcAuipc  = 7'b0010111,
		opcStore  = 7'b0100011,
		opcRType  = 7'b0110011,
		opcLui    = 7'b0110111,
		opcBranch = 7'b1100011,
		opcJalr   = 7'b1100111,
		opcJal    = 7'b1101111
	} opcodeT;

	// ALU operations, opNull marks an illegal instruction or a reset value
	typedef enum logic [4:0]
	{
		opAdd,
		opSub,
		opSll,
		opSlt,
		opSltu,
		opXor,
		opSrl,
		opSra,
		opOr,
		opAnd,
		opLui,
		opMul,
		opMulh,
		opMulhsu,
		opMulhu,
		opDiv,
		opDivu,
		opRem,
		opRemu,
		opNull
	} aluOpT;

	// Integer funct3 codes
	localparam logic [2:0] funct3Add  = 3'd0; // Also SUB
	localparam logic [2:0] funct3Sll  = 3'd1;
	localparam logic [2:0] funct3Slt  = 3'd2;
	localparam logic [2:0] funct3Sltu = 3'd3;
	localparam logic [2:0] funct3Xor  = 3'd4;
	localparam logic [2:0] funct3Srl  = 3'd5; // Also SRA
	localparam logic [2:0] funct3Or   = 3'd6;
	localparam logic [2:0] funct3And  = 3'd7;

	// M-extension funct3 codes
	localparam logic [2:0] funct3Mul    = 3'd0;
	localparam logic [2:0] funct3Mulh   = 3'd1;
	localparam logic [2:0] funct3Mulhsu = 3'd2;
	localparam logic [2:0] funct3Mulhu  = 3'd3;
	localparam logic [2:0] funct3Div    = 3'd4;
	localparam logic [2:0] funct3Divu   = 3'd5;
	localparam logic [2:0] funct3Rem    = 3'd6;
	localparam logic [2:0] funct3Remu   = 3'd7;

	// funct7 codes
	localparam logic [6:0] funct7Base   = 7'b0000000;
	localparam logic [6:0] funct7Alt    = 7'b0100000; // SUB and SRA
	localparam logic [6:0] funct7MulDiv = 7'b0000001;

	// Write-back source
	typedef enum logic [1:0]
	{
		wbAlu     = 2'b00,
		wbPcPlus4 = 2'b01,
		wbMem     = 2'b10
	} mem2RegT;

	// Next-PC source
	typedef enum logic [1:0]
	{
		pcNext   = 2'b00,
		pcBranch = 2'b01,
		pcJal    = 2'b10,
		pcJalr   = 2'b11
	} pcSrcT;

	// Fetch address fault
	typedef enum logic [1:0]
	{
		faultNone       = 2'b00,
		faultMisaligned = 2'b01,
		faultOutOfText  = 2'b10
	} pcFaultT;

	// Text segment, both bounds inclusive
	localparam logic [xLen-1:0] textBegin = 32'h0040_0000;
	localparam logic [xLen-1:0] textEnd   = 32'h0040_fffc;

endpackage

/* hw/aluOpDecoder.sv */
`timescale 1ns/1ps

module aluOpDecoder
	import decodePkg::*;
(
	input  logic [2:0] funct3,
	input  logic [6:0] funct7,
	input  logic       isImm,
	output aluOpT      aluOp,
	output logic       aluLegal
);

	logic  altSel; // funct7 selects SUB or SRA
	aluOpT baseOp;
	aluOpT mulDivOp;

	assign altSel = (funct7 == funct7Alt);

	// Base integer operation from funct3
	always_comb
	begin
		case (funct3)
			funct3Add:  baseOp = (altSel && !isImm) ? opSub : opAdd; // No SUBI
			funct3Sll:  baseOp = opSll;
			funct3Slt:  baseOp = opSlt;
			funct3Sltu: baseOp = opSltu;
			funct3Xor:  baseOp = opXor;
			funct3Srl:  baseOp = altSel ? opSra : opSrl; // SRAI shares the encoding
			funct3Or:   baseOp = opOr;
			funct3And:  baseOp = opAnd;
			default:    baseOp = opNull;
		endcase
	end

	// M extension
	always_comb
	begin
		case (funct3)
			funct3Mul:    mulDivOp = opMul;
			funct3Mulh:   mulDivOp = opMulh;
			funct3Mulhsu: mulDivOp = opMulhsu;
			funct3Mulhu:  mulDivOp = opMulhu;
			funct3Div:    mulDivOp = opDiv;
			funct3Divu:   mulDivOp = opDivu;
			funct3Rem:    mulDivOp = opRem;
			funct3Remu:   mulDivOp = opRemu;
			default:      mulDivOp = opNull;
		endcase
	end

	// Alt with a funct3 other than ADD or SRL falls through to the plain op
	always_comb
	begin
		aluLegal = 1'b1;
		if (isImm)
			aluOp = baseOp; // funct7 is immediate bits here
		else
		begin
			case (funct7)
				funct7Base,
				funct7Alt:    aluOp = baseOp;
				funct7MulDiv: aluOp = mulDivOp;
				default:
				begin
					aluOp    = opNull;
					aluLegal = 1'b0; // Unknown R-type funct7
				end
			endcase
		end
	end

endmodule

/* hw/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder
	import decodePkg::*;
(
	input  logic [xLen-1:0] instr,
	output logic            origAluA,
	output logic            origAluB,
	output logic            regWrite,
	output logic            memWrite,
	output logic            memRead,
	output mem2RegT         mem2Reg,
	output pcSrcT           pcSrc,
	output aluOpT           aluOp
);

	opcodeT     opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       isImm;
	aluOpT      fieldOp;  // From the function fields
	logic       aluLegal;

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign isImm  = (opcode == opcOpImm);

	aluOpDecoder u_aluOpDecoder
	(
		.funct3   (funct3),
		.funct7   (funct7),
		.isImm    (isImm),
		.aluOp    (fieldOp),
		.aluLegal (aluLegal)
	);

	always_comb
	begin
		// Illegal word unless a class below claims the opcode
		origAluA = 1'b0;
		origAluB = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memRead  = 1'b0;
		mem2Reg  = wbAlu;
		pcSrc    = pcNext;
		aluOp    = opNull;

		case (opcode)
			opcLoad:
			begin
				origAluB = 1'b1;
				regWrite = 1'b1;
				memRead  = 1'b1;
				aluOp    = opAdd; // Base plus offset
				mem2Reg  = wbMem;
			end
			opcOpImm,
			opcRType:
			begin
				if (aluLegal)
				begin
					origAluB = isImm; // Immediate only for OP-IMM
					regWrite = 1'b1;
					aluOp    = fieldOp;
				end
			end
			opcAuipc:
			begin
				origAluA = 1'b1; // PC as operand A
				origAluB = 1'b1;
				regWrite = 1'b1;
				aluOp    = opAdd;
			end
			opcStore:
			begin
				origAluB = 1'b1;
				memWrite = 1'b1;
				aluOp    = opAdd;
			end
			opcLui:
			begin
				origAluB = 1'b1;
				regWrite = 1'b1;
				aluOp    = opLui;
			end
			opcBranch:
			begin
				aluOp = opAdd;
				pcSrc = pcBranch;
			end
			opcJalr:
			begin
				regWrite = 1'b1;
				aluOp    = opAdd;
				mem2Reg  = wbPcPlus4; // Link address
				pcSrc    = pcJalr;
			end
			opcJal:
			begin
				regWrite = 1'b1;
				aluOp    = opAdd;
				mem2Reg  = wbPcPlus4;
				pcSrc    = pcJal;
			end
			default:
			begin
				aluOp = opNull; // Unknown opcode
			end
		endcase
	end

endmodule

/* hw/pcFaultCheck.sv */
`timescale 1ns/1ps

module pcFaultCheck
	import decodePkg::*;
(
	input  logic [xLen-1:0] pc,
	output pcFaultT         pcFault,
	output logic            csrWriteData
);

	logic misaligned;
	logic outOfText;

	assign misaligned = (pc[1:0] != 2'b00);
	assign outOfText  = (pc < textBegin) || (pc > textEnd); // Bounds inclusive

	// Alignment wins over the segment check
	always_comb
	begin
		if (misaligned)
			pcFault = faultMisaligned;
		else if (outOfText)
			pcFault = faultOutOfText;
		else
			pcFault = faultNone;
	end

	assign csrWriteData = (pcFault != faultNone); // Request trap CSR update

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
	import decodePkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            instrValid,
	input  logic [xLen-1:0] instr,
	input  logic [xLen-1:0] pc,
	output logic            ctrlValid,
	output logic            origAluA,
	output logic            origAluB,
	output logic            regWrite,
	output logic            memWrite,
	output logic            memRead,
	output mem2RegT         mem2Reg,
	output pcSrcT           pcSrc,
	output aluOpT           aluOp,
	output pcFaultT         pcFault,
	output logic            csrWriteData
);

	// Combinational control word
	logic    decAluA;
	logic    decAluB;
	logic    decRegWrite;
	logic    decMemWrite;
	logic    decMemRead;
	mem2RegT decMem2Reg;
	pcSrcT   decPcSrc;
	aluOpT   decAluOp;
	pcFaultT decPcFault;
	logic    decCsrWrite;

	mainDecoder u_mainDecoder
	(
		.instr    (instr),
		.origAluA (decAluA),
		.origAluB (decAluB),
		.regWrite (decRegWrite),
		.memWrite (decMemWrite),
		.memRead  (decMemRead),
		.mem2Reg  (decMem2Reg),
		.pcSrc    (decPcSrc),
		.aluOp    (decAluOp)
	);

	pcFaultCheck u_pcFaultCheck
	(
		.pc           (pc),
		.pcFault      (decPcFault),
		.csrWriteData (decCsrWrite)
	);

	// Decode pipeline register, one result per cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ctrlValid    <= 1'b0;
			origAluA     <= 1'b0;
			origAluB     <= 1'b0;
			regWrite     <= 1'b0;
			memWrite     <= 1'b0;
			memRead      <= 1'b0;
			mem2Reg      <= wbAlu;
			pcSrc        <= pcNext;
			aluOp        <= opNull;
			pcFault      <= faultNone;
			csrWriteData <= 1'b0;
		end
		else if (instrValid)
		begin
			ctrlValid    <= 1'b1;
			origAluA     <= decAluA;
			origAluB     <= decAluB;
			regWrite     <= decRegWrite;
			memWrite     <= decMemWrite;
			memRead      <= decMemRead;
			mem2Reg      <= decMem2Reg;
			pcSrc        <= decPcSrc;
			aluOp        <= decAluOp;
			pcFault      <= decPcFault;
			csrWriteData <= decCsrWrite;
		end
		else
		begin
			// Bubble: kill side effects, operand selects and aluOp hold
			ctrlValid    <= 1'b0;
			regWrite     <= 1'b0;
			memWrite     <= 1'b0;
			memRead      <= 1'b0;
			pcSrc        <= pcNext;
			pcFault      <= faultNone;
			csrWriteData <= 1'b0;
		end
	end

endmodule

/* tb/controlUnit_props.sv */
`timescale 1ns/1ps

module controlUnit_props
	import decodePkg::*;
(
	input logic    clk,
	input logic    rst,
	input logic    instrValid,
	input logic    ctrlValid,
	input logic    regWrite,
	input logic    memWrite,
	input logic    memRead,
	input logic    csrWriteData,
	input pcFaultT pcFault
);

	// Bubbles carry no side effects
	bubbleQuiet: assert property (@(posedge clk) disable iff (rst)
		!ctrlValid |-> !(regWrite || memWrite || memRead || csrWriteData))
		else $error("enable high while ctrlValid low");

	memExclusive: assert property (@(posedge clk) disable iff (rst)
		!(memWrite && memRead))
		else $error("memWrite and memRead both high");

	validDelay: assert property (@(posedge clk) disable iff (rst)
		ctrlValid == $past(instrValid))
		else $error("ctrlValid does not trail instrValid by one cycle");

	csrMatchesFault: assert property (@(posedge clk) disable iff (rst)
		csrWriteData == (pcFault != faultNone))
		else $error("csrWriteData disagrees with pcFault");

endmodule

bind controlUnit controlUnit_props u_controlUnitProps
(
	.clk          (clk),
	.rst          (rst),
	.instrValid   (instrValid),
	.ctrlValid    (ctrlValid),
	.regWrite     (regWrite),
	.memWrite     (memWrite),
	.memRead      (memRead),
	.csrWriteData (csrWriteData),
	.pcFault      (pcFault)
);

/* tb/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb
	import decodePkg::*;
();

	logic            clk;
	logic            rst;
	logic            instrValid;
	logic [xLen-1:0] instr;
	logic [xLen-1:0] pc;
	logic            ctrlValid;
	logic            origAluA;
	logic            origAluB;
	logic            regWrite;
	logic            memWrite;
	logic            memRead;
	mem2RegT         mem2Reg;
	pcSrcT           pcSrc;
	aluOpT           aluOp;
	pcFaultT         pcFault;
	logic            csrWriteData;
	logic [31:0]     lfsr;

	controlUnit u_controlUnit
	(
		.clk          (clk),
		.rst          (rst),
		.instrValid   (instrValid),
		.instr        (instr),
		.pc           (pc),
		.ctrlValid    (ctrlValid),
		.origAluA     (origAluA),
		.origAluB     (origAluB),
		.regWrite     (regWrite),
		.memWrite     (memWrite),
		.memRead      (memRead),
		.mem2Reg      (mem2Reg),
		.pcSrc        (pcSrc),
		.aluOp        (aluOp),
		.pcFault      (pcFault),
		.csrWriteData (csrWriteData)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Random rd, rs1 and rs2 around the decode fields
	function automatic logic [31:0] makeInstr(input logic [6:0] opc, input logic [2:0] f3,
		input logic [6:0] f7);
		return {f7, 5'(randBits(5)), 5'(randBits(5)), f3, 5'(randBits(5)), opc};
	endfunction

	function automatic logic [31:0] textPc();
		return textBegin + {14'(randBits(14)), 2'b00}; // Aligned inside the segment
	endfunction

	function automatic aluOpT refFieldOp(input logic [2:0] f3, input logic [6:0] f7,
		input logic imm);
		if (!imm && f7 == 7'b0000001)
		begin
			case (f3)
				3'd0: return opMul;
				3'd1: return opMulh;
				3'd2: return opMulhsu;
				3'd3: return opMulhu;
				3'd4: return opDiv;
				3'd5: return opDivu;
				3'd6: return opRem;
				default: return opRemu;
			endcase
		end
		case (f3)
			3'd0: return (!imm && f7 == 7'b0100000) ? opSub : opAdd;
			3'd1: return opSll;
			3'd2: return opSlt;
			3'd3: return opSltu;
			3'd4: return opXor;
			3'd5: return (f7 == 7'b0100000) ? opSra : opSrl;
			3'd6: return opOr;
			default: return opAnd;
		endcase
	endfunction

	// Reference decode table with en as {A, B, regWrite, memWrite, memRead}
	function automatic void refDecode(input logic [31:0] ins, output logic [4:0] en,
		output mem2RegT m2r, output pcSrcT ps, output aluOpT op);
		en  = 5'b00000;
		m2r = wbAlu;
		ps  = pcNext;
		op  = opNull;
		case (ins[6:0])
			7'b0000011:
			begin
				en  = 5'b01101;
				op  = opAdd;
				m2r = wbMem;
			end
			7'b0010011:
			begin
				en = 5'b01100;
				op = refFieldOp(ins[14:12], ins[31:25], 1'b1);
			end
			7'b0010111:
			begin
				en = 5'b11100;
				op = opAdd;
			end
			7'b0100011:
			begin
				en = 5'b01010;
				op = opAdd;
			end
			7'b0110011:
			begin
				if (ins[31:25] inside {7'b0000000, 7'b0100000, 7'b0000001})
				begin
					en = 5'b00100;
					op = refFieldOp(ins[14:12], ins[31:25], 1'b0);
				end
			end
			7'b0110111:
			begin
				en = 5'b01100;
				op = opLui;
			end
			7'b1100011:
			begin
				op = opAdd;
				ps = pcBranch;
			end
			7'b1100111:
			begin
				en  = 5'b00100;
				op  = opAdd;
				m2r = wbPcPlus4;
				ps  = pcJalr;
			end
			7'b1101111:
			begin
				en  = 5'b00100;
				op  = opAdd;
				m2r = wbPcPlus4;
				ps  = pcJal;
			end
			default: op = opNull; // Illegal
		endcase
	endfunction

	function automatic pcFaultT refFault(input logic [31:0] p);
		if (p[1:0] != 2'b00)
			return faultMisaligned;
		else if (p < 32'h0040_0000 || p > 32'h0040_fffc)
			return faultOutOfText;
		else
			return faultNone;
	endfunction

	task automatic failNow(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
			failNow($sformatf("FAILED at %0t: %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic checkAluOp(input aluOpT exp, input aluOpT act);
		if (act !== exp)
			failNow($sformatf("FAILED at %0t: aluOp expected %s got %s", $time,
				exp.name(), act.name()));
	endtask

	task automatic checkMem2Reg(input mem2RegT exp, input mem2RegT act);
		if (act !== exp)
			failNow($sformatf("FAILED at %0t: mem2Reg expected %0d got %0d", $time, exp, act));
	endtask

	task automatic checkPcSrc(input pcSrcT exp, input pcSrcT act);
		if (act !== exp)
			failNow($sformatf("FAILED at %0t: pcSrc expected %0d got %0d", $time, exp, act));
	endtask

	task automatic checkFault(input pcFaultT exp, input pcFaultT act);
		if (act !== exp)
			failNow($sformatf("FAILED at %0t: pcFault expected %0d got %0d", $time, exp, act));
	endtask

	task automatic checkWord(input logic [31:0] ins, input logic [31:0] p);
		logic [4:0] en;
		mem2RegT    m2r;
		pcSrcT      ps;
		aluOpT      op;
		pcFaultT    flt;
		refDecode(ins, en, m2r, ps, op);
		flt = refFault(p);
		checkBit("ctrlValid", 1'b1, ctrlValid);
		checkBit("origAluA", en[4], origAluA);
		checkBit("origAluB", en[3], origAluB);
		checkBit("regWrite", en[2], regWrite);
		checkBit("memWrite", en[1], memWrite);
		checkBit("memRead", en[0], memRead);
		checkMem2Reg(m2r, mem2Reg);
		checkPcSrc(ps, pcSrc);
		checkAluOp(op, aluOp);
		checkFault(flt, pcFault);
		checkBit("csrWriteData", flt != faultNone, csrWriteData);
	endtask

	task automatic checkBubble();
		checkBit("ctrlValid", 1'b0, ctrlValid);
		checkBit("regWrite", 1'b0, regWrite);
		checkBit("memWrite", 1'b0, memWrite);
		checkBit("memRead", 1'b0, memRead);
		checkBit("csrWriteData", 1'b0, csrWriteData);
		checkPcSrc(pcNext, pcSrc);
		checkFault(faultNone, pcFault);
	endtask

	task automatic waitForResult();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (ctrlValid !== 1'b1)
		begin
			if (cycles == 20)
				failNow("Timed out waiting for ctrlValid");
			else
			begin
				cycles++;
				@(negedge clk);
			end
		end
	endtask

	// One instruction followed by a bubble
	task automatic runOne(input logic [31:0] ins, input logic [31:0] p);
		@(posedge clk);
		instrValid <= 1'b1;
		instr      <= ins;
		pc         <= p;
		@(posedge clk);
		instrValid <= 1'b0;
		waitForResult();
		checkWord(ins, p);
	endtask

	task automatic testReset();
		@(negedge clk);
		checkBubble();
		checkAluOp(opNull, aluOp);
	endtask

	task automatic testOpcodeClasses();
		logic [6:0] opcs [9] = '{7'b0000011, 7'b0010011, 7'b0010111, 7'b0100011,
			7'b0110011, 7'b0110111, 7'b1100011, 7'b1100111, 7'b1101111};
		for (int i = 0; i < 9; i++)
			for (int k = 0; k < 4; k++)
				runOne(makeInstr(opcs[i], 3'(randBits(3)),
					(opcs[i] == 7'b0110011) ? 7'b0000000 : 7'(randBits(7))), textPc());
	endtask

	task automatic testFunctFields();
		for (int f = 0; f < 8; f++)
		begin
			runOne(makeInstr(7'b0110011, f[2:0], funct7Base), textPc());
			runOne(makeInstr(7'b0110011, f[2:0], funct7Alt), textPc());
			runOne(makeInstr(7'b0110011, f[2:0], funct7MulDiv), textPc());
			runOne(makeInstr(7'b0010011, f[2:0], funct7Base), textPc());
			runOne(makeInstr(7'b0010011, f[2:0], funct7Alt), textPc());
		end
	endtask

	task automatic testIllegal();
		runOne(makeInstr(7'b1111111, 3'(randBits(3)), 7'(randBits(7))), textPc());
		runOne(makeInstr(7'b0001111, 3'(randBits(3)), 7'(randBits(7))), textPc());
		runOne(makeInstr(7'b0110011, 3'd0, 7'b0000010), textPc());
		runOne(makeInstr(7'b0110011, 3'd5, 7'b1000000), textPc());
	endtask

	task automatic testFaults();
		logic [31:0] pcs [7] = '{32'h0040_0102, 32'h003f_fffc, 32'h0041_0000,
			32'h0000_0001, 32'h0040_0000, 32'h0040_fffc, 32'h0040_fffe};
		for (int i = 0; i < 7; i++)
			runOne(makeInstr(7'b0110111, 3'(randBits(3)), 7'(randBits(7))), pcs[i]);
	endtask

	// Results must trail inputs by exactly one edge
	task automatic testStream();
		logic [31:0] insQ [12];
		logic [31:0] pcQ  [12];
		logic        vQ   [12];
		for (int i = 0; i < 12; i++)
		begin
			vQ[i]   = (i % 4 != 3);
			insQ[i] = makeInstr((i % 2 == 0) ? 7'b0110011 : 7'b0000011,
				3'(randBits(3)), (i % 3 == 0) ? funct7MulDiv : funct7Base);
			pcQ[i]  = (i == 5) ? 32'h0040_0006 : textPc();
		end
		for (int i = 0; i <= 12; i++)
		begin
			@(posedge clk);
			instrValid <= (i < 12) ? vQ[i] : 1'b0;
			instr      <= (i < 12) ? insQ[i] : '0;
			pc         <= (i < 12) ? pcQ[i] : '0;
			@(negedge clk);
			if (i > 0)
			begin
				if (vQ[i-1])
					checkWord(insQ[i-1], pcQ[i-1]);
				else
					checkBubble();
			end
		end
	endtask

	initial
	begin
		lfsr       = 32'h4d49_9f16;
		rst        = 1'b1;
		instrValid = 1'b0;
		instr      = '0;
		pc         = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		testReset();
		testOpcodeClasses();
		testFunctFields();
		testIllegal();
		testFaults();
		testStream();
		$display("Testbench passed");
		$finish;
	end

	// Global limit against a hung run
	initial
	begin
		#200us;
		failNow("Simulation ran past its time limit");
	end

endmodule

/* flist.f */
hw/decodePkg.sv
hw/aluOpDecoder.sv
hw/mainDecoder.sv
hw/pcFaultCheck.sv
hw/controlUnit.sv
tb/controlUnit_props.sv
tb/controlUnitTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = controlUnitTb
FLIST     = flist.f
LOG       = sim.log
FAIL_MSG  = Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
